// File: verilog/rv_alu_cfg.svh
`ifndef RV_ALU_CFG_SVH
`define RV_ALU_CFG_SVH

// Data path and instruction word width
`define XLEN 32

// Micro-op queue entries, a power of two and at least 2
`define UOP_QUEUE_DEPTH 4

`endif

// File: verilog/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } rv_opcode_e;

    // funct7, instr[31:25]
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;   // SUB, SRA, SRAI

    // funct3, instr[14:12], arithmetic group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

endpackage

`default_nettype wire

// File: verilog/alu_pkg.sv
`include "rv_alu_cfg.svh"

`default_nettype none

package alu_pkg;

    // Standard ALU control codes plus SLT and SLTU
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_OR   = 4'd4,
        ALU_SLTU = 4'd5,
        ALU_XOR  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SLL  = 4'd10,
        ALU_SRA  = 4'd12,
        ALU_LUI  = 4'd13
    } alu_op_e;

    // Queue entry of 4 + 2 * XLEN bits
    typedef struct packed {
        alu_op_e           op;
        logic [`XLEN-1:0]  operand_a;
        logic [`XLEN-1:0]  operand_b;
    } alu_uop_t;

endpackage

`default_nettype wire

// File: verilog/uop_if.sv
`include "rv_alu_cfg.svh"

`default_nettype none

interface uop_if
    import alu_pkg::*;
();

    logic              valid;
    alu_op_e           op;
    logic [`XLEN-1:0]  operand_a;
    logic [`XLEN-1:0]  operand_b;

    modport sender (
        output valid,
        output op,
        output operand_a,
        output operand_b
    );

    modport receiver (
        input  valid,
        input  op,
        input  operand_a,
        input  operand_b
    );

endinterface

`default_nettype wire

// File: verilog/instr_decoder.sv
`include "rv_alu_cfg.svh"

`default_nettype none

module instr_decoder
    import rv_isa_pkg::*;
    import alu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              instr_valid,
    input  wire logic [`XLEN-1:0]  instr,
    input  wire logic [`XLEN-1:0]  rs1_data,
    input  wire logic [`XLEN-1:0]  rs2_data,
    input  wire logic [`XLEN-1:0]  pc,
    output logic                   illegal,
    uop_if.sender                  out
);

    rv_opcode_e        opcode;
    logic [2:0]        funct3;
    logic              f7_base;
    logic              f7_alt;
    logic              is_reg;
    logic [`XLEN-1:0]  imm;
    alu_op_e           arith_op;
    logic              arith_legal;
    alu_op_e           dec_op;
    logic [`XLEN-1:0]  dec_a;
    logic [`XLEN-1:0]  dec_b;
    logic              dec_legal;

    assign opcode  = rv_opcode_e'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign f7_base = (instr[31:25] == FUNCT7_BASE);
    assign f7_alt  = (instr[31:25] == FUNCT7_ALT);
    assign is_reg  = (opcode == OP);

    always_comb
    begin
        case (opcode)
            STORE:       imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            LUI, AUIPC:  imm = {instr[31:12], 12'b0};
            JAL:         imm = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12],
                                instr[20], instr[30:21], 1'b0};
            default:     imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};   // I-type
        endcase
    end

    // Shared by OP and OP_IMM, only OP checks funct7 on every funct3
    always_comb
    begin
        arith_op    = ALU_ADD;
        arith_legal = f7_base;
        case (funct3)
            F3_ADD_SUB:
            begin
                arith_op    = (is_reg && f7_alt) ? ALU_SUB : ALU_ADD;
                arith_legal = !is_reg || f7_base || f7_alt;
            end
            F3_SLL:      arith_op = ALU_SLL;
            F3_SLT:
            begin
                arith_op    = ALU_SLT;
                arith_legal = !is_reg || f7_base;
            end
            F3_SLTU:
            begin
                arith_op    = ALU_SLTU;
                arith_legal = !is_reg || f7_base;
            end
            F3_XOR:
            begin
                arith_op    = ALU_XOR;
                arith_legal = !is_reg || f7_base;
            end
            F3_SRL_SRA:
            begin
                arith_op    = f7_alt ? ALU_SRA : ALU_SRL;
                arith_legal = f7_base || f7_alt;
            end
            F3_OR:
            begin
                arith_op    = ALU_OR;
                arith_legal = !is_reg || f7_base;
            end
            F3_AND:
            begin
                arith_op    = ALU_AND;
                arith_legal = !is_reg || f7_base;
            end
            default:     arith_legal = 1'b0;
        endcase
    end

    always_comb
    begin
        dec_op    = ALU_ADD;
        dec_a     = rs1_data;
        dec_b     = imm;
        dec_legal = 1'b1;
        case (opcode)
            OP:
            begin
                dec_op    = arith_op;
                dec_b     = rs2_data;
                dec_legal = arith_legal;
            end
            OP_IMM:
            begin
                dec_op    = arith_op;
                dec_legal = arith_legal;
            end
            LOAD, STORE: dec_op = ALU_ADD;   // Address only
            BRANCH:
            begin
                dec_op = ALU_SUB;
                dec_b  = rs2_data;
            end
            JAL, JALR:
            begin
                dec_a = pc;   // Link value
                dec_b = `XLEN'd4;
            end
            LUI:
            begin
                dec_op = ALU_LUI;
                dec_a  = '0;
            end
            AUIPC:       dec_a = pc;
            default:     dec_legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out.valid <= 1'b0;
            illegal   <= 1'b0;
        end
        else
        begin
            out.valid <= instr_valid && dec_legal;
            illegal   <= instr_valid && !dec_legal;
        end
    end

    always_ff @(posedge clk)
    begin
        if (instr_valid)
        begin
            out.op        <= dec_op;
            out.operand_a <= dec_a;
            out.operand_b <= dec_b;
        end
    end

endmodule

`default_nettype wire

// File: verilog/uop_queue.sv
`include "rv_alu_cfg.svh"

`default_nettype none

module uop_queue
    import alu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  arst_n,
    uop_if.receiver    wr,
    input  wire logic  pop,
    uop_if.sender      rd,
    output logic       overflow
);

    localparam int PTR_W = $clog2(`UOP_QUEUE_DEPTH);

    alu_uop_t          mem [`UOP_QUEUE_DEPTH];
    alu_uop_t          head;
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              full;
    logic              empty;
    logic              push_ok;
    logic              pop_ok;

    // Full is taken before any pop of the same cycle
    assign full    = (count == (PTR_W + 1)'(`UOP_QUEUE_DEPTH));
    assign empty   = (count == '0);
    assign push_ok = wr.valid && !full;
    assign pop_ok  = pop && !empty;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;   // Wraps, depth is a power of two
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (wr.valid && full)
                overflow <= 1'b1;   // Sticky
        end
    end

    always_ff @(posedge clk)
    begin
        if (push_ok)
            mem[wr_ptr] <= '{op: wr.op, operand_a: wr.operand_a, operand_b: wr.operand_b};
    end

    assign head         = mem[rd_ptr];
    assign rd.valid     = !empty;
    assign rd.op        = head.op;
    assign rd.operand_a = head.operand_a;
    assign rd.operand_b = head.operand_b;

endmodule

`default_nettype wire

// File: verilog/alu_execute.sv
`include "rv_alu_cfg.svh"

`default_nettype none

module alu_execute
    import alu_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         arst_n,
    uop_if.receiver           in,
    output logic              pop,
    output logic              result_valid,
    output logic [`XLEN-1:0]  result
);

    typedef enum logic {
        IDLE,
        SHIFTING
    } state_e;

    state_e            state;
    alu_op_e           sh_op;
    logic [4:0]        sh_cnt;
    logic [`XLEN-1:0]  sh_data;
    logic [4:0]        shamt;
    logic              is_shift;
    logic              multi_cycle;
    logic              finish;
    logic [`XLEN-1:0]  alu_out;
    alu_op_e           step_op;
    logic [`XLEN-1:0]  step_in;
    logic [`XLEN-1:0]  step_out;
    logic [`XLEN-1:0]  result_next;

    function automatic logic [`XLEN-1:0] shift_step(alu_op_e op, logic [`XLEN-1:0] v);
        case (op)
            ALU_SLL: return {v[`XLEN-2:0], 1'b0};
            ALU_SRA: return {v[`XLEN-1], v[`XLEN-1:1]};
            default: return {1'b0, v[`XLEN-1:1]};   // SRL
        endcase
    endfunction

    assign shamt       = in.operand_b[4:0];
    assign is_shift    = (in.op == ALU_SLL) || (in.op == ALU_SRL) || (in.op == ALU_SRA);
    assign multi_cycle = is_shift && (shamt > 5'd1);
    assign pop         = (state == IDLE) && in.valid;
    assign finish      = (pop && !multi_cycle) || ((state == SHIFTING) && (sh_cnt == 5'd1));

    // First shift step happens on the pop cycle
    assign step_op  = (state == IDLE) ? in.op : sh_op;
    assign step_in  = (state == IDLE) ? in.operand_a : sh_data;
    assign step_out = shift_step(step_op, step_in);

    always_comb
    begin
        case (in.op)
            ALU_SUB:  alu_out = in.operand_a - in.operand_b;
            ALU_AND:  alu_out = in.operand_a & in.operand_b;
            ALU_OR:   alu_out = in.operand_a | in.operand_b;
            ALU_XOR:  alu_out = in.operand_a ^ in.operand_b;
            ALU_SLT:  alu_out = {{(`XLEN-1){1'b0}},
                                 $signed(in.operand_a) < $signed(in.operand_b)};
            ALU_SLTU: alu_out = {{(`XLEN-1){1'b0}}, in.operand_a < in.operand_b};
            ALU_LUI:  alu_out = in.operand_b;
            default:  alu_out = in.operand_a + in.operand_b;
        endcase
    end

    always_comb
    begin
        if (state == SHIFTING)
            result_next = step_out;
        else if (!is_shift)
            result_next = alu_out;
        else if (shamt == 5'd0)
            result_next = in.operand_a;
        else
            result_next = step_out;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state        <= IDLE;
            sh_cnt       <= '0;
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= finish;
            case (state)
                IDLE:
                begin
                    if (pop && multi_cycle)
                    begin
                        state  <= SHIFTING;
                        sh_cnt <= shamt - 5'd1;   // Steps left
                    end
                end
                SHIFTING:
                begin
                    if (sh_cnt == 5'd1)
                        state <= IDLE;
                    else
                        sh_cnt <= sh_cnt - 5'd1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop || (state == SHIFTING))
            sh_data <= step_out;
        if (pop)
            sh_op <= in.op;
        if (finish)
            result <= result_next;
    end

endmodule

`default_nettype wire

// File: verilog/rv_alu_slice.sv
`include "rv_alu_cfg.svh"

`default_nettype none

module rv_alu_slice (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              instr_valid,
    input  wire logic [`XLEN-1:0]  instr,
    input  wire logic [`XLEN-1:0]  rs1_data,
    input  wire logic [`XLEN-1:0]  rs2_data,
    input  wire logic [`XLEN-1:0]  pc,
    output logic                   result_valid,
    output logic [`XLEN-1:0]       result,
    output logic                   illegal,
    output logic                   overflow
);

    logic  pop;

    uop_if dec_if ();   // Decoder to queue, push pulse
    uop_if exe_if ();   // Queue head to ALU, level

    instr_decoder i_instr_decoder (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .pc          (pc),
        .illegal     (illegal),
        .out         (dec_if.sender)
    );

    uop_queue i_uop_queue (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr       (dec_if.receiver),
        .pop      (pop),
        .rd       (exe_if.sender),
        .overflow (overflow)
    );

    alu_execute i_alu_execute (
        .clk          (clk),
        .arst_n       (arst_n),
        .in           (exe_if.receiver),
        .pop          (pop),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk    = 1'b0;
        arst_n = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial
    begin
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;   // Release away from the active edge
    end

endmodule

`default_nettype wire

// File: testbench/tb_rv_alu_slice.sv
`include "rv_alu_cfg.svh"

`default_nettype none

module tb_rv_alu_slice
    import rv_isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        logic [31:0] instr;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] pc;
        int          gap;   // Random gap mask where 0 forces back to back
        logic [31:0] exp;
        bit          ill;
    } row_t;

    logic        clk;
    logic        arst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] pc;
    logic        result_valid;
    logic [31:0] result;
    logic        illegal;
    logic        overflow;

    row_t        rows[$];
    row_t        idle_row;
    logic [31:0] exp_q[$];
    int          lat_q[$];   // Latency of each entry in the DUT queue
    logic [31:0] exp_head;
    logic [31:0] lfsr;
    bit          table_ready;
    int          err_value;
    int          err_other;
    int          cyc;
    int          alu_free;
    bit          exp_ovf;
    bit          exp_illegal;
    row_t        s1;
    row_t        s2;
    bit          s1_v;
    bit          s2_v;

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(4)) i_tb_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rv_alu_slice i_rv_alu_slice (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .pc           (pc),
        .result_valid (result_valid),
        .result       (result),
        .illegal      (illegal),
        .overflow     (overflow)
    );

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [6:0] op);
        return {f7, 5'd2, 5'd1, f3, 5'd3, op};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [2:0] f3, logic [6:0] op);
        return {imm, 5'd1, f3, 5'd3, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] enc_u(logic [19:0] imm, logic [6:0] op);
        return {imm, 5'd3, op};
    endfunction

    // Serial shifts take one cycle per bit and everything else one
    function automatic int latency_of(row_t r);
        logic [6:0] op;
        logic [2:0] f3;
        int         amt;
        op  = r.instr[6:0];
        f3  = r.instr[14:12];
        amt = 1;
        if ((op == OP || op == OP_IMM) && (f3 == F3_SLL || f3 == F3_SRL_SRA))
            amt = (op == OP) ? int'(r.rs2[4:0]) : int'(r.instr[24:20]);
        return (amt == 0) ? 1 : amt;
    endfunction

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic get_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            v    = (v << 1) | lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic add_row(input logic [31:0] i, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] p, input int g, input logic [31:0] e,
                           input bit ill);
        row_t r;
        r = '{instr: i, rs1: a, rs2: b, pc: p, gap: g, exp: e, ill: ill};
        rows.push_back(r);
    endtask

    // Advance the reference model by one edge and drive the next inputs
    task automatic step_cycle(input bit v, input row_t r);
        int cb;
        @(posedge clk);
        cyc++;
        cb = lat_q.size();
        if (cb > 0 && cyc >= alu_free)
            alu_free = cyc + lat_q.pop_front();
        if (s2_v && !s2.ill)
        begin
            if (cb == `UOP_QUEUE_DEPTH)
                exp_ovf = 1'b1;   // Dropped push
            else
            begin
                lat_q.push_back(latency_of(s2));
                exp_q.push_back(s2.exp);
            end
        end
        exp_illegal = s1_v && s1.ill;
        s2   = s1;
        s2_v = s1_v;
        s1   = r;
        s1_v = v;
        instr_valid <= v;
        instr       <= r.instr;
        rs1_data    <= r.rs1;
        rs2_data    <= r.rs2;
        pc          <= r.pc;
    endtask

    task automatic build_table();
        logic [31:0] n16;
        logic [31:0] sh;
        n16 = 32'hffff_fff0;
        sh  = 32'h8000_00f1;
        add_row(enc_r(FUNCT7_BASE, F3_ADD_SUB, OP), n16, 32'h5, 0, 3, 32'hffff_fff5, 0);
        add_row(enc_r(FUNCT7_ALT, F3_ADD_SUB, OP), n16, 32'h5, 0, 3, 32'hffff_ffeb, 0);
        add_row(enc_r(FUNCT7_BASE, F3_AND, OP), n16, 32'h5, 0, 3, 32'h0, 0);
        add_row(enc_r(FUNCT7_BASE, F3_OR, OP), n16, 32'h5, 0, 3, 32'hffff_fff5, 0);
        add_row(enc_r(FUNCT7_BASE, F3_XOR, OP), n16, 32'h5, 0, 3, 32'hffff_fff5, 0);
        add_row(enc_r(FUNCT7_BASE, F3_SLT, OP), n16, 32'h5, 0, 3, 32'h1, 0);
        add_row(enc_r(FUNCT7_BASE, F3_SLTU, OP), n16, 32'h5, 0, 3, 32'h0, 0);
        add_row(enc_r(FUNCT7_BASE, F3_SLT, OP), 32'h5, n16, 0, 3, 32'h0, 0);
        add_row(enc_r(FUNCT7_BASE, F3_SLTU, OP), 32'h5, n16, 0, 3, 32'h1, 0);
        add_row(enc_i(12'hfff, F3_ADD_SUB, OP_IMM), 32'h1234, 0, 0, 3, 32'h0000_1233, 0);
        add_row(enc_i(12'h0ff, F3_XOR, OP_IMM), 32'h1234, 0, 0, 3, 32'h0000_12cb, 0);
        add_row(enc_i(12'hf0f, F3_AND, OP_IMM), 32'h1234, 0, 0, 3, 32'h0000_1204, 0);
        add_row(enc_i(12'h800, F3_OR, OP_IMM), 32'h1234, 0, 0, 3, 32'hffff_fa34, 0);
        add_row(enc_i(12'hfff, F3_SLT, OP_IMM), 32'h1234, 0, 0, 3, 32'h0, 0);
        add_row(enc_i(12'hfff, F3_SLTU, OP_IMM), 32'h1234, 0, 0, 3, 32'h1, 0);
        add_row(enc_i({FUNCT7_BASE, 5'd4}, F3_SLL, OP_IMM), sh, 0, 0, 3, 32'h0000_0f10, 0);
        add_row(enc_i({FUNCT7_BASE, 5'd31}, F3_SRL_SRA, OP_IMM), sh, 0, 0, 3, 32'h1, 0);
        add_row(enc_i({FUNCT7_ALT, 5'd31}, F3_SRL_SRA, OP_IMM), sh, 0, 0, 3, 32'hffff_ffff, 0);
        add_row(enc_i({FUNCT7_ALT, 5'd4}, F3_SRL_SRA, OP_IMM), sh, 0, 0, 3, 32'hf800_000f, 0);
        add_row(enc_i({FUNCT7_BASE, 5'd0}, F3_SRL_SRA, OP_IMM), sh, 0, 0, 3, sh, 0);
        add_row(enc_i({FUNCT7_BASE, 5'd1}, F3_SLL, OP_IMM), sh, 0, 0, 3, 32'h0000_01e2, 0);
        add_row(enc_r(FUNCT7_BASE, F3_SLL, OP), sh, 32'h0, 0, 3, sh, 0);
        add_row(enc_r(FUNCT7_BASE, F3_SRL_SRA, OP), sh, 32'h21, 0, 3, 32'h4000_0078, 0);
        add_row(enc_r(FUNCT7_ALT, F3_SRL_SRA, OP), sh, 32'h10, 0, 3, 32'hffff_8000, 0);
        add_row(enc_r(FUNCT7_BASE, F3_SLL, OP), sh, 32'h1f, 0, 3, 32'h8000_0000, 0);
        add_row(enc_i(12'h7fc, 3'b010, LOAD), 32'h1000, 0, 0, 3, 32'h0000_17fc, 0);
        add_row(enc_s(12'hff8), 32'h2000, 32'h55, 0, 3, 32'h0000_1ff8, 0);
        add_row({7'b0, 5'd2, 5'd1, 3'b000, 5'b0, BRANCH}, 32'ha, 32'h14, 0, 3,
                32'hffff_fff6, 0);
        add_row(enc_u(20'h00800, JAL), 0, 0, 32'h100, 3, 32'h0000_0104, 0);
        add_row(enc_i(12'h010, 3'b000, JALR), 32'h77, 0, 32'h200, 3, 32'h0000_0204, 0);
        add_row(enc_u(20'h12345, LUI), 32'h99, 0, 0, 3, 32'h1234_5000, 0);
        add_row(enc_u(20'h00001, AUIPC), 32'h99, 0, 32'h400, 3, 32'h0000_1400, 0);
        add_row(enc_r(7'b0000001, F3_ADD_SUB, OP), 32'h1, 32'h2, 0, 3, 0, 1);   // M extension
        add_row({25'h0, 7'b1111111}, 0, 0, 0, 3, 0, 1);
        add_row(enc_r(FUNCT7_ALT, F3_XOR, OP), 32'h1, 32'h2, 0, 3, 0, 1);
        add_row(enc_i({FUNCT7_ALT, 5'd3}, F3_SLL, OP_IMM), 32'h1, 0, 0, 3, 0, 1);
        add_row(enc_r(FUNCT7_BASE, F3_ADD_SUB, OP), 32'h10, 32'h20, 0, 3, 32'h30, 0);
        // Burst of more shifts than the queue can hold
        for (int i = 0; i < 8; i++)
            add_row(enc_i({FUNCT7_BASE, 5'd31}, F3_SRL_SRA, OP_IMM),
                    i[0] ? 32'h8000_0000 : 32'h7fff_ffff, 0, 0, 0, {31'b0, i[0]}, 0);
        add_row(enc_r(FUNCT7_BASE, F3_OR, OP), 32'hf0, 32'h0f, 0, 3, 32'hff, 0);
    endtask

    always @(negedge clk)
    begin
        if (arst_n && table_ready)
        begin
            if (result_valid)
            begin
                assert (exp_q.size() != 0)
                else
                begin
                    err_other++;
                    $display("Result %h came out with no instruction left to match it", result);
                end
                if (exp_q.size() != 0)
                begin
                    exp_head = exp_q.pop_front();
                    assert (result === exp_head)
                    else
                    begin
                        err_value++;
                        $display("Fail: result expected %h got %h", exp_head, result);
                    end
                end
            end
            assert (illegal === exp_illegal)
            else
            begin
                err_value++;
                $display("Fail: illegal expected %h got %h", exp_illegal, illegal);
            end
            assert (overflow === exp_ovf)
            else
            begin
                err_value++;
                $display("Fail: overflow expected %h got %h", exp_ovf, overflow);
            end
        end
    end

    initial
    begin
        wait (table_ready);
        repeat (rows.size() * 40) @(posedge clk);
        $display("Watchdog expired, the DUT stopped producing results");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        int g;
        instr_valid = 1'b0;
        instr       = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        pc          = '0;
        lfsr        = 32'h5bcd_3ad2;
        err_value   = 0;
        err_other   = 0;
        cyc         = 0;
        alu_free    = 0;
        exp_ovf     = 0;
        exp_illegal = 0;
        s1_v        = 0;
        s2_v        = 0;
        idle_row    = '{instr: 0, rs1: 0, rs2: 0, pc: 0, gap: 0, exp: 0, ill: 0};
        s1          = idle_row;
        s2          = idle_row;
        build_table();
        wait (arst_n === 1'b1);
        @(negedge clk);
        assert (!result_valid && !illegal && !overflow)
        else
        begin
            err_value++;
            $display("Fail: after reset result_valid %h illegal %h overflow %h expected 0",
                     result_valid, illegal, overflow);
        end
        table_ready = 1;
        foreach (rows[k])
        begin
            get_bits(2, g);
            repeat (g & rows[k].gap) step_cycle(0, idle_row);
            step_cycle(1, rows[k]);
        end
        while (s1_v || s2_v || lat_q.size() != 0 || exp_q.size() != 0)
            step_cycle(0, idle_row);
        repeat (35) step_cycle(0, idle_row);   // Catch stray results
        assert (overflow === 1'b1)
        else
        begin
            err_other++;
            $display("The burst of shifts did not set the overflow flag");
        end
        $display("Errors: value %0d, other %0d", err_value, err_other);
        if (err_value == 0 && err_other == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_alu_slice.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/alu_pkg.sv
verilog/uop_if.sv
verilog/instr_decoder.sv
verilog/uop_queue.sv
verilog/alu_execute.sv
verilog/rv_alu_slice.sv
testbench/tb_clock_gen.sv
testbench/tb_rv_alu_slice.sv
